/* bench/bp_checker.sv */
// frontend reference model and scoreboard
// keeps its own entry table and fetch address, compares at the falling edge
`timescale 1ns/100ps

module bp_checker import bp_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            debug_mode_i,
    input  logic            fetch_ready_i,
    input  logic            fetch_valid_i,
    input  logic [VLEN-1:0] fetch_pc_i,
    input  logic            fetch_pred_taken_i,
    input  logic            res_valid_i,
    input  logic [VLEN-1:0] res_pc_i,
    input  logic            res_taken_i,
    input  logic [VLEN-1:0] res_target_i,
    input  logic            mispredict_i,
    output int unsigned     error_count_o,
    output int unsigned     check_count_o
);

    // entry table indexed by address bits 5..2, row then slot
    logic            m_valid  [NR_ENTRIES];
    logic [VLEN-1:0] m_target [NR_ENTRIES];

    // expected fetch state
    logic            exp_valid;
    logic [VLEN-1:0] exp_pc;
    logic            held;
    logic            held_taken;
    logic [VLEN-1:0] held_next;

    int unsigned     errors = 0;
    int unsigned     checks = 0;

    assign error_count_o = errors;
    assign check_count_o = checks;

    // ----------------------------------------
    // model rules
    // ----------------------------------------
    // next block for the offered address, frozen once the block stalls
    function automatic void predict(output logic taken, output logic [VLEN-1:0] next_pc);
        int unsigned row_base;
        int unsigned s;
        taken    = 1'b0;
        next_pc  = {exp_pc[VLEN-1:3], 3'b000} + 32'd8;
        row_base = {exp_pc[5:3], 1'b0};
        if (held) begin
            taken   = held_taken;
            next_pc = held_next;
        end else begin
            for (s = exp_pc[2]; s < INSTR_PER_FETCH; s++) begin
                if (!taken && m_valid[row_base + s]) begin
                    taken   = 1'b1;
                    next_pc = m_target[row_base + s];
                end
            end
        end
    endfunction

    // outcome of the presented branch against the current table
    function automatic br_outcome_e classify();
        int unsigned idx;
        idx = res_pc_i[5:2];
        if (!res_valid_i)
            return BR_CORRECT;
        if (m_valid[idx] && !res_taken_i)
            return BR_MISS_TAKEN;
        if (!m_valid[idx] && res_taken_i)
            return BR_MISS_NOT_TAKEN;
        if (m_valid[idx] && res_taken_i && (m_target[idx] != res_target_i))
            return BR_BAD_TARGET;
        return BR_CORRECT;
    endfunction

    task automatic check_value(input string name, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // model state, advanced at each edge
    // ----------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin : model_update
        logic            taken;
        logic [VLEN-1:0] nxt;
        br_outcome_e     oc;
        int unsigned     idx;
        if (!rst_ni) begin
            exp_valid  = 1'b0;
            exp_pc     = BOOT_PC;
            held       = 1'b0;
            held_taken = 1'b0;
            held_next  = '0;
            for (int i = 0; i < NR_ENTRIES; i++)
                m_valid[i] = 1'b0;
        end else begin
            predict(taken, nxt);
            oc  = classify();
            idx = res_pc_i[5:2];
            // redirect drops the offered block
            if (oc != BR_CORRECT) begin
                exp_pc = res_taken_i ? res_target_i : res_pc_i + 32'd4;
                held   = 1'b0;
            end else if (exp_valid && fetch_ready_i) begin
                exp_pc = nxt;
                held   = 1'b0;
            end else if (exp_valid) begin
                held       = 1'b1;
                held_taken = taken;
                held_next  = nxt;
            end
            exp_valid = 1'b1;
            // table repair, flush first, debug freezes updates
            if (flush_i) begin
                for (int i = 0; i < NR_ENTRIES; i++)
                    m_valid[i] = 1'b0;
            end else if (!debug_mode_i) begin
                case (oc)
                    BR_MISS_TAKEN: m_valid[idx] = 1'b0;
                    BR_MISS_NOT_TAKEN, BR_BAD_TARGET: begin
                        m_valid[idx]  = 1'b1;
                        m_target[idx] = res_target_i;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // comparison, mid cycle where everything has settled
    // ----------------------------------------
    always @(negedge clk_i) begin : compare
        logic            taken;
        logic [VLEN-1:0] nxt;
        br_outcome_e     oc;
        if (rst_ni) begin
            predict(taken, nxt);
            oc = classify();
            check_value("fetch_valid_o", fetch_valid_i, exp_valid);
            if (exp_valid) begin
                check_value("fetch_pc_o", fetch_pc_i, exp_pc);
                check_value("fetch_pred_taken_o", fetch_pred_taken_i, taken);
            end
            check_value("mispredict_o", mispredict_i, oc != BR_CORRECT);
        end
    end

endmodule

/* bench/bp_frontend_assert.sv */
// frontend protocol assertions
// bound into the frontend top, watches the fetch handshake and reset state
`timescale 1ns/100ps

module bp_frontend_assert import bp_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            fetch_valid_i,
    input logic            fetch_ready_i,
    input logic [VLEN-1:0] fetch_pc_i,
    input logic            fetch_pred_taken_i,
    input logic            redirect_valid_i,
    input logic            res_valid_i,
    input logic            mispredict_i
);

    // read by the testbench top at the end of the run
    int unsigned fail_count = 0;

    // a misprediction only exists for a presented branch
    mispredict_needs_res: assert property (
        @(posedge clk_i) disable iff (!rst_ni) mispredict_i |-> res_valid_i
    ) else begin
        fail_count++;
        $error("mispredict_o high without res_valid_i");
    end

    // nothing offered while reset is held
    no_valid_in_reset: assert property (
        @(posedge clk_i) !rst_ni |-> !fetch_valid_i
    ) else begin
        fail_count++;
        $error("fetch_valid_o high during reset");
    end

    // stalled block keeps address and prediction unless redirected
    stall_holds_block: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (fetch_valid_i && !fetch_ready_i && !redirect_valid_i)
            |=> ($stable(fetch_pc_i) && $stable(fetch_pred_taken_i))
    ) else begin
        fail_count++;
        $error("fetch block changed while stalled");
    end

endmodule

bind bp_frontend bp_frontend_assert bp_assert (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_pc_i         (fetch_pc_o),
    .fetch_pred_taken_i (fetch_pred_taken_o),
    .redirect_valid_i   (redirect_valid),
    .res_valid_i        (res_valid_i),
    .mispredict_i       (mispredict_o)
);

/* bench/tb_bp_frontend.sv */
// frontend testbench
// random fetch back-pressure, resolved branches, debug windows and flushes
`timescale 1ns/100ps

module tb_bp_frontend import bp_pkg::*; ();

    localparam int unsigned CLK_PERIOD    = 4;
    localparam int unsigned RESET_CYCLES  = 3;
    localparam int unsigned NUM_CYCLES    = 3000;
    localparam int unsigned MARGIN_CYCLES = 200;
    localparam int unsigned DRIVE_DELAY   = 1;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            debug_mode_i;
    logic            fetch_ready_i;
    logic            fetch_valid_o;
    logic [VLEN-1:0] fetch_pc_o;
    logic            fetch_pred_taken_o;
    logic            res_valid_i;
    logic [VLEN-1:0] res_pc_i;
    logic            res_taken_i;
    logic [VLEN-1:0] res_target_i;
    logic            mispredict_o;

    int unsigned     error_count;
    int unsigned     check_count;
    int unsigned     total_fails;
    int              seed;
    int unsigned     debug_left;

    bp_frontend dut_i (.*);

    bp_checker model_chk (
        .clk_i, .rst_ni, .flush_i, .debug_mode_i, .fetch_ready_i,
        .fetch_valid_i      (fetch_valid_o),
        .fetch_pc_i         (fetch_pc_o),
        .fetch_pred_taken_i (fetch_pred_taken_o),
        .res_valid_i, .res_pc_i, .res_taken_i, .res_target_i,
        .mispredict_i       (mispredict_o),
        .error_count_o      (error_count),
        .check_count_o      (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic int unsigned pick(input int unsigned n);
        return {$random(seed)} % n;
    endfunction

    // bit 6 picks one of two 64-byte regions whose entries alias by index
    function automatic logic [VLEN-1:0] pool_addr();
        return 32'h0000_1000 | (VLEN'(pick(2)) << 6) | (VLEN'(pick(16)) << 2);
    endfunction

    task automatic drive_cycle();
        fetch_ready_i = (pick(10) < 7);
        res_valid_i   = (pick(10) < 4);
        res_pc_i      = pool_addr();
        res_taken_i   = (pick(2) == 1);
        res_target_i  = pool_addr();
        // short debug windows
        if (debug_left > 0) begin
            debug_left--;
            debug_mode_i = 1'b1;
        end else if (pick(100) == 0) begin
            debug_left   = 4 + pick(8);
            debug_mode_i = 1'b1;
        end else begin
            debug_mode_i = 1'b0;
        end
        flush_i = (pick(250) == 0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        seed          = 32'h9218;
        debug_left    = 0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        debug_mode_i  = 1'b0;
        fetch_ready_i = 1'b0;
        res_valid_i   = 1'b0;
        res_pc_i      = '0;
        res_taken_i   = 1'b0;
        res_target_i  = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY rst_ni = 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            drive_cycle();
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        res_valid_i  = 1'b0;
        flush_i      = 1'b0;
        debug_mode_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
        total_fails = error_count + dut_i.bp_assert.fail_count;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, dut_i.bp_assert.fail_count);
        if (total_fails == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_CYCLES + MARGIN_CYCLES));
        $display("run timed out before the stimulus sequence completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* bp_frontend.f */
hw/bp_pkg.sv
hw/btb_if.sv
hw/btb.sv
hw/fetch_pc_gen.sv
hw/branch_resolve.sv
hw/bp_frontend.sv
bench/bp_frontend_assert.sv
bench/bp_checker.sv
bench/tb_bp_frontend.sv

/* hw/bp_frontend.sv */
// branch prediction frontend
// fetch address generator, branch target buffer and branch resolution
// joined through the buffer bus and a redirect path
`timescale 1ns/100ps

module bp_frontend import bp_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            debug_mode_i,

    // fetch block stream
    input  logic            fetch_ready_i,
    output logic            fetch_valid_o,
    output logic [VLEN-1:0] fetch_pc_o,
    output logic            fetch_pred_taken_o,

    // resolved branches from execute
    input  logic            res_valid_i,
    input  logic [VLEN-1:0] res_pc_i,
    input  logic            res_taken_i,
    input  logic [VLEN-1:0] res_target_i,
    output logic            mispredict_o
);

    // redirect from resolution into fetch
    logic            redirect_valid;
    logic [VLEN-1:0] redirect_pc;

    btb_if btb_bus ();

    // ----------------------------------------
    // blocks
    // ----------------------------------------
    btb i_btb (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .debug_mode_i (debug_mode_i),
        .btb_io       (btb_bus.store)
    );

    fetch_pc_gen i_fetch_pc_gen (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .btb_io             (btb_bus.fetch),
        .redirect_valid_i   (redirect_valid),
        .redirect_pc_i      (redirect_pc),
        .fetch_ready_i      (fetch_ready_i),
        .fetch_valid_o      (fetch_valid_o),
        .fetch_pc_o         (fetch_pc_o),
        .fetch_pred_taken_o (fetch_pred_taken_o)
    );

    // purely combinational, no clock needed
    branch_resolve i_branch_resolve (
        .btb_io           (btb_bus.resolve),
        .res_valid_i      (res_valid_i),
        .res_pc_i         (res_pc_i),
        .res_taken_i      (res_taken_i),
        .res_target_i     (res_target_i),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .mispredict_o     (mispredict_o)
    );

endmodule

/* hw/bp_pkg.sv */
// branch prediction package
// address split, buffer entry and update formats, outcome codes
package bp_pkg;

    // ----------------------------------------
    // sizes and address layout
    // ----------------------------------------
    localparam int unsigned VLEN            = 32;
    localparam int unsigned INSTR_PER_FETCH = 2;
    localparam int unsigned NR_ENTRIES      = 16;
    // one row holds all slots of a fetch block
    localparam int unsigned NR_ROWS         = NR_ENTRIES / INSTR_PER_FETCH;
    // byte offset bits of a 32-bit instruction
    localparam int unsigned OFFSET          = 2;
    // slot select bits inside a block
    localparam int unsigned ROW_ADDR_BITS   = $clog2(INSTR_PER_FETCH);
    // row index bits above the slot bits
    localparam int unsigned ROW_IDX_BITS    = $clog2(NR_ROWS);
    localparam int unsigned FETCH_BYTES     = INSTR_PER_FETCH * (1 << OFFSET);
    localparam logic [VLEN-1:0] BOOT_PC     = 32'h0000_1000;

    // row index, address bits 5..3
    function automatic logic [ROW_IDX_BITS-1:0] row_of(input logic [VLEN-1:0] pc);
        return pc[OFFSET+ROW_ADDR_BITS +: ROW_IDX_BITS];
    endfunction

    // slot inside the block, address bit 2
    function automatic logic [ROW_ADDR_BITS-1:0] slot_of(input logic [VLEN-1:0] pc);
        return pc[OFFSET +: ROW_ADDR_BITS];
    endfunction

    // ----------------------------------------
    // entry, update and outcome types
    // ----------------------------------------
    typedef struct packed {
        logic            valid;
        logic [VLEN-1:0] target_address;
    } btb_prediction_t;

    typedef enum logic [1:0] {
        UPD_NONE,
        UPD_WRITE,
        UPD_CLEAR
    } btb_upd_op_e;

    typedef struct packed {
        btb_upd_op_e     op;
        logic [VLEN-1:0] pc;
        logic [VLEN-1:0] target_address;
    } btb_update_t;

    typedef enum logic [1:0] {
        BR_CORRECT,
        BR_MISS_TAKEN,
        BR_MISS_NOT_TAKEN,
        BR_BAD_TARGET
    } br_outcome_e;

endpackage

/* hw/branch_resolve.sv */
// branch resolution
// checks each resolved branch against its buffer entry,
// repairs the entry and redirects fetch on a misprediction
`timescale 1ns/100ps

module branch_resolve import bp_pkg::*; (
    btb_if.resolve          btb_io,
    input  logic            res_valid_i,
    input  logic [VLEN-1:0] res_pc_i,
    input  logic            res_taken_i,
    input  logic [VLEN-1:0] res_target_i,
    output logic            redirect_valid_o,
    output logic [VLEN-1:0] redirect_pc_o,
    output logic            mispredict_o
);

    br_outcome_e     outcome;
    btb_upd_op_e     upd_op;
    btb_prediction_t entry;
    logic            target_diff;
    logic [VLEN-1:0] fall_through_pc;

    // the entry covering the resolved branch, read in the same cycle
    assign btb_io.query_pc = res_pc_i;
    assign entry           = btb_io.query_entry;

    assign target_diff     = (entry.target_address != res_target_i);

    // next instruction after the branch
    assign fall_through_pc = res_pc_i + VLEN'(FETCH_BYTES / INSTR_PER_FETCH);

    // ----------------------------------------
    // classification
    // ----------------------------------------
    always_comb begin
        outcome = BR_CORRECT;
        upd_op  = UPD_NONE;
        if (res_valid_i) begin
            if (entry.valid && !res_taken_i) begin
                // predicted taken, fell through
                outcome = BR_MISS_TAKEN;
                upd_op  = UPD_CLEAR;
            end else if (!entry.valid && res_taken_i) begin
                // no entry yet, learn the target
                outcome = BR_MISS_NOT_TAKEN;
                upd_op  = UPD_WRITE;
            end else if (entry.valid && res_taken_i && target_diff) begin
                // taken as predicted, went somewhere else
                outcome = BR_BAD_TARGET;
                upd_op  = UPD_WRITE;
            end
        end
    end

    // ----------------------------------------
    // repair and redirect
    // ----------------------------------------
    assign btb_io.update.op             = upd_op;
    assign btb_io.update.pc             = res_pc_i;
    assign btb_io.update.target_address = res_target_i;

    // only non-correct when res_valid_i is high
    assign mispredict_o     = (outcome != BR_CORRECT);
    assign redirect_valid_o = mispredict_o;
    assign redirect_pc_o    = res_taken_i ? res_target_i : fall_through_pc;

endmodule

/* hw/btb.sv */
// branch target buffer
// direct mapped, one entry per instruction slot, no tags
// lookup and query read combinationally, updates land at the clock edge
// flush drops every entry and wins over an update
`timescale 1ns/100ps

module btb import bp_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic debug_mode_i,
    btb_if.store btb_io
);

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    logic [ROW_IDX_BITS-1:0]  lookup_row;
    logic [ROW_IDX_BITS-1:0]  query_row;
    logic [ROW_ADDR_BITS-1:0] query_slot;
    logic [ROW_IDX_BITS-1:0]  upd_row;
    logic [ROW_ADDR_BITS-1:0] upd_slot;

    // update qualifiers
    logic                     upd_en;
    logic                     upd_write;

    // valid bits per row and slot
    logic [NR_ROWS-1:0][INSTR_PER_FETCH-1:0] valid_q;
    // targets, only meaningful while the matching valid bit is set
    logic [VLEN-1:0]                         target_q [NR_ROWS][INSTR_PER_FETCH];

    // fetch side only needs the row, the whole block is returned
    assign lookup_row = row_of(btb_io.lookup_pc);

    // resolve side picks one slot of its row
    assign query_row  = row_of(btb_io.query_pc);
    assign query_slot = slot_of(btb_io.query_pc);

    assign upd_row    = row_of(btb_io.update.pc);
    assign upd_slot   = slot_of(btb_io.update.pc);

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_lookup
        // entries alias by index, no tag compare
        assign btb_io.lookup_pred[i].valid          = valid_q[lookup_row][i];
        assign btb_io.lookup_pred[i].target_address = target_q[lookup_row][i];
    end

    assign btb_io.query_entry.valid          = valid_q[query_row][query_slot];
    assign btb_io.query_entry.target_address = target_q[query_row][query_slot];

    // ----------------------------------------
    // update
    // ----------------------------------------
    // debug mode freezes the table contents
    assign upd_en    = (btb_io.update.op != UPD_NONE) && !debug_mode_i;

    // target only changes on a write, a clear just drops the valid bit
    assign upd_write = upd_en && (btb_io.update.op == UPD_WRITE) && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // evict everything, pending update is lost
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[upd_row][upd_slot] <= (btb_io.update.op == UPD_WRITE);
        end
    end

    // target storage
    always_ff @(posedge clk_i) begin
        if (upd_write) begin
            target_q[upd_row][upd_slot] <= btb_io.update.target_address;
        end
    end

endmodule

/* hw/btb_if.sv */
// branch target buffer bus
// carries the fetch lookup, the resolve query and the update
`timescale 1ns/100ps

interface btb_if import bp_pkg::*; ();

    // fetch side lookup, one prediction per slot of the block
    logic [VLEN-1:0]                              lookup_pc;
    btb_prediction_t [INSTR_PER_FETCH-1:0]        lookup_pred;

    // resolve side query of a single entry
    logic [VLEN-1:0]                              query_pc;
    btb_prediction_t                              query_entry;

    // repair from the resolve side
    btb_update_t                                  update;

    // fetch address generator
    modport fetch (
        output lookup_pc,
        input  lookup_pred
    );

    // branch resolution
    modport resolve (
        output query_pc,
        output update,
        input  query_entry
    );

    // the buffer itself
    modport store (
        input  lookup_pc,
        input  query_pc,
        input  update,
        output lookup_pred,
        output query_entry
    );

endinterface

/* hw/fetch_pc_gen.sv */
// fetch address generator
// offers one aligned two-instruction block per cycle on a valid/ready stream
// next block comes from the buffer prediction or the sequential address
// a redirect from branch resolution overrides stall and advance
`timescale 1ns/100ps

module fetch_pc_gen import bp_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    btb_if.fetch            btb_io,
    input  logic            redirect_valid_i,
    input  logic [VLEN-1:0] redirect_pc_i,
    input  logic            fetch_ready_i,
    output logic            fetch_valid_o,
    output logic [VLEN-1:0] fetch_pc_o,
    output logic            fetch_pred_taken_o
);

    logic                     valid_q;
    logic [VLEN-1:0]          pc_q;
    logic [ROW_ADDR_BITS-1:0] cur_slot;

    // scan result over the looked-up row
    logic                     hit;
    logic [VLEN-1:0]          hit_target;
    logic [VLEN-1:0]          block_base;
    logic [VLEN-1:0]          seq_pc;

    // decision kept while the block waits
    logic                     hold_q;
    logic                     hold_taken_q;
    logic [VLEN-1:0]          hold_pc_q;

    logic                     pred_taken;
    logic [VLEN-1:0]          next_pc;
    logic                     transfer;

    assign btb_io.lookup_pc = pc_q;
    assign cur_slot         = slot_of(pc_q);

    // ----------------------------------------
    // prediction scan
    // ----------------------------------------
    // first valid slot at or after the fetch slot wins
    always_comb begin
        hit        = 1'b0;
        hit_target = '0;
        for (int i = 0; i < INSTR_PER_FETCH; i++) begin
            if (!hit && (i >= int'(cur_slot)) && btb_io.lookup_pred[i].valid) begin
                hit        = 1'b1;
                hit_target = btb_io.lookup_pred[i].target_address;
            end
        end
    end

    // fall through to the next aligned block
    assign block_base = pc_q & ~(VLEN'(FETCH_BYTES - 1));
    assign seq_pc     = block_base + VLEN'(FETCH_BYTES);

    // while stalled the first decision stays, table updates do not leak in
    assign pred_taken = hold_q ? hold_taken_q : hit;
    assign next_pc    = hold_q ? hold_pc_q : (hit ? hit_target : seq_pc);

    assign transfer   = valid_q && fetch_ready_i;

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= 1'b0;
            pc_q         <= BOOT_PC;
            hold_q       <= 1'b0;
            hold_taken_q <= 1'b0;
        end else begin
            // rises on the first edge out of reset and stays
            valid_q <= 1'b1;
            if (redirect_valid_i) begin
                // offered block is dropped
                pc_q   <= redirect_pc_i;
                hold_q <= 1'b0;
            end else if (transfer) begin
                pc_q   <= next_pc;
                hold_q <= 1'b0;
            end else if (valid_q) begin
                // back-pressure, freeze the prediction
                hold_q       <= 1'b1;
                hold_taken_q <= pred_taken;
            end
        end
    end

    // held next address, only read while hold_q is set
    always_ff @(posedge clk_i) begin
        if (valid_q && !fetch_ready_i && !redirect_valid_i) begin
            hold_pc_q <= next_pc;
        end
    end

    assign fetch_valid_o      = valid_q;
    assign fetch_pc_o         = pc_q;
    assign fetch_pred_taken_o = pred_taken;

endmodule
